//--- gmii_bus_pkg.sv
package gmii_bus_pkg;

  // host I/O bus of the Z80 kind
  typedef logic [15:0] io_addr_t;
  typedef logic [7:0]  io_data_t;

  // register offsets, taken from address bits 2 to 0
  localparam logic [2:0] reg_status     = 3'd0;
  localparam logic [2:0] reg_status_msk = 3'd1;
  localparam logic [2:0] reg_control    = 3'd2;
  localparam logic [2:0] reg_rx_len0    = 3'd3;
  localparam logic [2:0] reg_rx_len1    = 3'd4;
  localparam logic [2:0] reg_rx_data    = 3'd5;
  localparam logic [2:0] reg_tx_data    = 3'd6;
  localparam logic [2:0] reg_cfg        = 3'd7;

  // returned on any read that selects no register
  localparam io_data_t int_vector = 8'd207;

  // bit positions inside the status and status mask registers
  localparam int stat_rx_done = 0;
  localparam int stat_tx_done = 1;

endpackage

//--- gmii_frame_pkg.sv
package gmii_frame_pkg;

  // one byte on the GMII pins
  typedef logic [7:0] byte_t;

  // frame length in bytes, read by the host as two bytes
  typedef logic [15:0] frame_len_t;

  typedef enum logic [1:0] {
    rx_idle,
    rx_armed,
    rx_capture,
    rx_done
  } rx_state_t;

  typedef enum logic [1:0] {
    tx_idle,
    tx_send,
    tx_hold
  } tx_state_t;

endpackage

//--- gmii_byte_fifo.sv
`timescale 1ns/100ps

module gmii_byte_fifo
  import gmii_frame_pkg::*;
#(
  parameter int unsigned BUF_DEPTH_LOG2 = 6
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    wr_valid,
  output logic                    wr_ready,
  input  byte_t                   wr_data,
  output logic                    rd_valid,
  input  logic                    rd_ready,
  output byte_t                   rd_data,
  output logic [BUF_DEPTH_LOG2:0] count
);

  localparam int unsigned DEPTH = 1 << BUF_DEPTH_LOG2;

  byte_t                     mem [DEPTH];
  logic [BUF_DEPTH_LOG2-1:0] wr_ptr;
  logic [BUF_DEPTH_LOG2-1:0] rd_ptr;
  logic                      wr_fire;
  logic                      rd_fire;

  assign wr_ready = (count != (BUF_DEPTH_LOG2 + 1)'(DEPTH));
  assign rd_valid = (count != '0);
  assign rd_data  = mem[rd_ptr];

  assign wr_fire = wr_valid && wr_ready;
  assign rd_fire = rd_valid && rd_ready;

  always_ff @(posedge clk)
  begin
    if (wr_fire)
      mem[wr_ptr] <= wr_data;
  end

  // pointers wrap naturally at the power of two depth
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_fire)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_fire)
        rd_ptr <= rd_ptr + 1'b1;
      if (wr_fire && !rd_fire)
        count <= count + 1'b1;
      else if (rd_fire && !wr_fire)
        count <= count - 1'b1;
    end
  end

endmodule

//--- simple_gmii_regs.sv
`timescale 1ns/100ps

module simple_gmii_regs
  import gmii_bus_pkg::*;
  import gmii_frame_pkg::*;
#(
  parameter logic [4:0] BLOCK_BASE = 5'd1
) (
  input  logic       clk,
  input  logic       reset,
  input  io_addr_t   addr,
  input  io_data_t   wr_data,
  output io_data_t   rd_data,
  output logic       doe,
  input  logic       rd_n,
  input  logic       wr_n,
  input  logic       iorq_n,
  input  logic [1:0] status_set,
  output logic [1:0] status_msk,
  output logic       control,
  input  logic       control_clr,
  input  byte_t      rx_len0,
  input  byte_t      rx_len1,
  input  byte_t      rx_data,
  output logic       rx_data_stb,
  output byte_t      tx_data,
  output logic       tx_data_stb,
  output logic       cfg,
  output logic       int_n
);

  logic       block_sel;
  logic       rd_en;
  logic       wr_en;
  logic       status_wr;
  logic       status_msk_wr;
  logic       control_wr;
  logic       tx_data_wr;
  logic       cfg_wr;
  logic       rx_data_rd;
  logic       rx_data_rd_d;
  logic       tx_data_wr_d;
  logic [1:0] status;
  logic       status_int;

  assign block_sel = !iorq_n && (addr[7:3] == BLOCK_BASE);
  assign rd_en     = block_sel && !rd_n;
  assign wr_en     = block_sel && !wr_n;

  assign status_wr     = wr_en && (addr[2:0] == reg_status);
  assign status_msk_wr = wr_en && (addr[2:0] == reg_status_msk);
  assign control_wr    = wr_en && (addr[2:0] == reg_control);
  assign tx_data_wr    = wr_en && (addr[2:0] == reg_tx_data);
  assign cfg_wr        = wr_en && (addr[2:0] == reg_cfg);
  assign rx_data_rd    = rd_en && (addr[2:0] == reg_rx_data);

  always_comb
  begin
    rd_data = int_vector;
    if (rd_en)
    begin
      case (addr[2:0])
        reg_status:     rd_data = io_data_t'(status);
        reg_status_msk: rd_data = io_data_t'(status_msk);
        reg_control:    rd_data = io_data_t'(control);
        reg_rx_len0:    rd_data = rx_len0;
        reg_rx_len1:    rd_data = rx_len1;
        reg_rx_data:    rd_data = rx_data;
        reg_tx_data:    rd_data = tx_data;
        reg_cfg:        rd_data = io_data_t'(cfg);
      endcase
    end
  end

  assign doe   = rd_en;
  assign int_n = ~status_int;

  // a write of 1 clears a status bit and wins over a set in the same cycle
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      status     <= '0;
      status_int <= 1'b0;
    end
    else
    begin
      status     <= (status | status_set) & ~(status_wr ? wr_data[1:0] : 2'b00);
      status_int <= |(status & ~status_msk);
    end
  end

  // control can only be set by the host, the receive engine clears it
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      status_msk <= '0;
      control    <= 1'b0;
      tx_data    <= '0;
      cfg        <= 1'b0;
    end
    else
    begin
      if (status_msk_wr)
        status_msk <= wr_data[1:0];
      control <= (control | (control_wr & wr_data[0])) & ~control_clr;
      if (tx_data_wr)
        tx_data <= wr_data;
      if (cfg_wr)
        cfg <= wr_data[0];
    end
  end

  // one strobe per access, no matter how many cycles the strobe is held
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rx_data_rd_d <= 1'b0;
      tx_data_wr_d <= 1'b0;
      rx_data_stb  <= 1'b0;
      tx_data_stb  <= 1'b0;
    end
    else
    begin
      rx_data_rd_d <= rx_data_rd;
      tx_data_wr_d <= tx_data_wr;
      rx_data_stb  <= rx_data_rd && !rx_data_rd_d;
      tx_data_stb  <= tx_data_wr && !tx_data_wr_d;
    end
  end

endmodule

//--- gmii_rx_frame.sv
`timescale 1ns/100ps

module gmii_rx_frame
  import gmii_frame_pkg::*;
#(
  parameter int unsigned BUF_DEPTH_LOG2 = 6
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  armed,
  input  logic  gmii_rx_dv,
  input  byte_t gmii_rxd,
  output byte_t rx_len0,
  output byte_t rx_len1,
  output byte_t rx_data,
  input  logic  rx_data_stb,
  output logic  frame_done
);

  rx_state_t  state;
  logic       rx_dv_d;
  logic       frame_start;
  logic       buf_wr_valid;
  logic       buf_wr_ready;
  logic       buf_rd_valid;
  byte_t      buf_rd_data;
  frame_len_t len_cnt;

  // a frame is taken only from its first byte, never from the middle
  assign frame_start  = (state == rx_armed) && armed && gmii_rx_dv && !rx_dv_d;
  assign buf_wr_valid = gmii_rx_dv && (frame_start || (state == rx_capture));

  // an empty buffer reads as zero rather than a stale head
  assign rx_data = buf_rd_valid ? buf_rd_data : '0;

  gmii_byte_fifo #(
    .BUF_DEPTH_LOG2(BUF_DEPTH_LOG2)
  ) u_rx_fifo (
    .clk     (clk),
    .reset   (reset),
    .wr_valid(buf_wr_valid),
    .wr_ready(buf_wr_ready),
    .wr_data (gmii_rxd),
    .rd_valid(buf_rd_valid),
    .rd_ready(rx_data_stb),
    .rd_data (buf_rd_data),
    .count   ()
  );

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state      <= rx_idle;
      rx_dv_d    <= 1'b0;
      len_cnt    <= '0;
      rx_len0    <= '0;
      rx_len1    <= '0;
      frame_done <= 1'b0;
    end
    else
    begin
      rx_dv_d    <= gmii_rx_dv;
      frame_done <= 1'b0;
      case (state)
        rx_idle:
          if (armed)
            state <= rx_armed;
        rx_armed:
          if (frame_start)
          begin
            state   <= rx_capture;
            len_cnt <= frame_len_t'(buf_wr_ready);
          end
          else if (!armed)
            state <= rx_idle;
        rx_capture:
          if (gmii_rx_dv)
            len_cnt <= len_cnt + frame_len_t'(buf_wr_ready);
          else
          begin
            rx_len0    <= len_cnt[7:0];
            rx_len1    <= len_cnt[15:8];
            frame_done <= 1'b1;
            state      <= rx_done;
          end
        rx_done:
          // wait for control to drop so one arm gives one frame
          if (!armed)
            state <= rx_idle;
        default:
          state <= rx_idle;
      endcase
    end
  end

endmodule

//--- gmii_tx_frame.sv
`timescale 1ns/100ps

module gmii_tx_frame
  import gmii_frame_pkg::*;
#(
  parameter int unsigned BUF_DEPTH_LOG2 = 6
) (
  input  logic  clk,
  input  logic  reset,
  input  byte_t tx_data,
  input  logic  tx_data_stb,
  input  logic  go,
  output logic  gmii_tx_en,
  output byte_t gmii_txd,
  output logic  frame_sent
);

  tx_state_t state;
  logic      buf_rd_valid;
  logic      buf_rd_ready;
  byte_t     buf_rd_data;
  logic      pop;

  // the first byte leaves in the same cycle that starts the frame
  assign buf_rd_ready = ((state == tx_idle) && go) || (state == tx_send);
  assign pop          = buf_rd_ready && buf_rd_valid;

  gmii_byte_fifo #(
    .BUF_DEPTH_LOG2(BUF_DEPTH_LOG2)
  ) u_tx_fifo (
    .clk     (clk),
    .reset   (reset),
    .wr_valid(tx_data_stb),
    .wr_ready(),
    .wr_data (tx_data),
    .rd_valid(buf_rd_valid),
    .rd_ready(buf_rd_ready),
    .rd_data (buf_rd_data),
    .count   ()
  );

  always_ff @(posedge clk)
  begin
    if (pop)
      gmii_txd <= buf_rd_data;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state      <= tx_idle;
      gmii_tx_en <= 1'b0;
      frame_sent <= 1'b0;
    end
    else
    begin
      frame_sent <= 1'b0;
      case (state)
        tx_idle:
          if (pop)
          begin
            gmii_tx_en <= 1'b1;
            state      <= tx_send;
          end
        tx_send:
          if (!pop)
          begin
            gmii_tx_en <= 1'b0;
            frame_sent <= 1'b1;
            state      <= tx_hold;
          end
        tx_hold:
          if (!go)
            state <= tx_idle;
        default:
          state <= tx_idle;
      endcase
    end
  end

endmodule

//--- simple_gmii.sv
`timescale 1ns/100ps

module simple_gmii
  import gmii_bus_pkg::*;
  import gmii_frame_pkg::*;
#(
  parameter logic [4:0]  BLOCK_BASE     = 5'd1,
  parameter int unsigned BUF_DEPTH_LOG2 = 6
) (
  input  logic       clk,
  input  logic       reset,
  input  io_addr_t   addr,
  input  io_data_t   wr_data,
  output io_data_t   rd_data,
  output logic       doe,
  input  logic       rd_n,
  input  logic       wr_n,
  input  logic       iorq_n,
  output logic       int_n,
  output logic [1:0] status_msk,
  input  logic       gmii_rx_dv,
  input  byte_t      gmii_rxd,
  output logic       gmii_tx_en,
  output byte_t      gmii_txd
);

  logic [1:0] status_set;
  logic       control;
  logic       cfg;
  logic       rx_done;
  logic       tx_sent;
  byte_t      rx_len0;
  byte_t      rx_len1;
  byte_t      rx_data;
  logic       rx_data_stb;
  byte_t      tx_data;
  logic       tx_data_stb;

  assign status_set[stat_rx_done] = rx_done;
  assign status_set[stat_tx_done] = tx_sent;

  simple_gmii_regs #(
    .BLOCK_BASE(BLOCK_BASE)
  ) u_regs (
    .clk        (clk),
    .reset      (reset),
    .addr       (addr),
    .wr_data    (wr_data),
    .rd_data    (rd_data),
    .doe        (doe),
    .rd_n       (rd_n),
    .wr_n       (wr_n),
    .iorq_n     (iorq_n),
    .status_set (status_set),
    .status_msk (status_msk),
    .control    (control),
    .control_clr(rx_done),
    .rx_len0    (rx_len0),
    .rx_len1    (rx_len1),
    .rx_data    (rx_data),
    .rx_data_stb(rx_data_stb),
    .tx_data    (tx_data),
    .tx_data_stb(tx_data_stb),
    .cfg        (cfg),
    .int_n      (int_n)
  );

  gmii_rx_frame #(
    .BUF_DEPTH_LOG2(BUF_DEPTH_LOG2)
  ) u_rx_frame (
    .clk        (clk),
    .reset      (reset),
    .armed      (control),
    .gmii_rx_dv (gmii_rx_dv),
    .gmii_rxd   (gmii_rxd),
    .rx_len0    (rx_len0),
    .rx_len1    (rx_len1),
    .rx_data    (rx_data),
    .rx_data_stb(rx_data_stb),
    .frame_done (rx_done)
  );

  gmii_tx_frame #(
    .BUF_DEPTH_LOG2(BUF_DEPTH_LOG2)
  ) u_tx_frame (
    .clk        (clk),
    .reset      (reset),
    .tx_data    (tx_data),
    .tx_data_stb(tx_data_stb),
    .go         (cfg),
    .gmii_tx_en (gmii_tx_en),
    .gmii_txd   (gmii_txd),
    .frame_sent (tx_sent)
  );

endmodule

//--- tb_simple_gmii.sv
`timescale 1ns/100ps

module tb_simple_gmii
  import gmii_bus_pkg::*;
  import gmii_frame_pkg::*;
();

  localparam logic [4:0]  block_base     = 5'd1;
  localparam int unsigned buf_depth_log2 = 6;
  localparam io_data_t    expected_vector = 8'd207;

  // six directed tests of at most 300 cycles each, with a wide margin on top
  localparam int test_count      = 6;
  localparam int max_test_cycles = 300;
  localparam int cycle_limit     = 10 * test_count * max_test_cycles + 2000;

  logic       clk;
  logic       reset;
  io_addr_t   addr;
  io_data_t   wr_data;
  io_data_t   rd_data;
  logic       doe;
  logic       rd_n;
  logic       wr_n;
  logic       iorq_n;
  logic       int_n;
  logic [1:0] status_msk;
  logic       gmii_rx_dv;
  byte_t      gmii_rxd;
  logic       gmii_tx_en;
  byte_t      gmii_txd;

  integer     seed;
  int         cycles = 0;
  int         errors;
  byte_t      rx_sent[$];
  byte_t      tx_seen[$];
  int         tx_pulses;
  logic       tx_en_prev;
  frame_len_t last_rx_len;

  simple_gmii #(
    .BLOCK_BASE    (block_base),
    .BUF_DEPTH_LOG2(buf_depth_log2)
  ) u_simple_gmii (
    .clk       (clk),
    .reset     (reset),
    .addr      (addr),
    .wr_data   (wr_data),
    .rd_data   (rd_data),
    .doe       (doe),
    .rd_n      (rd_n),
    .wr_n      (wr_n),
    .iorq_n    (iorq_n),
    .int_n     (int_n),
    .status_msk(status_msk),
    .gmii_rx_dv(gmii_rx_dv),
    .gmii_rxd  (gmii_rxd),
    .gmii_tx_en(gmii_tx_en),
    .gmii_txd  (gmii_txd)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  // transmit pins are sampled in the middle of the clock, away from the edge
  always @(negedge clk)
  begin
    if (gmii_tx_en)
    begin
      tx_seen.push_back(gmii_txd);
      if (!tx_en_prev)
        tx_pulses = tx_pulses + 1;
    end
    tx_en_prev = gmii_tx_en;
  end

  task automatic stop_on_error(input string msg);
    errors = errors + 1;
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_data(input io_data_t got, input io_data_t exp, input string what);
    if (got !== exp)
      stop_on_error($sformatf("Error at %0t ns: %s is %0d, expected %0d",
                              $time, what, got, exp));
  endtask

  task automatic check_len(input frame_len_t got, input frame_len_t exp, input string what);
    if (got !== exp)
      stop_on_error($sformatf("Error at %0t ns: %s is %0d, expected %0d",
                              $time, what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      stop_on_error($sformatf("Error at %0t ns: %s is %b, expected %b",
                              $time, what, got, exp));
  endtask

  function automatic io_addr_t reg_addr(input logic [2:0] offset);
    return {8'h00, block_base, offset};
  endfunction

  function automatic int random_len();
    return 5 + int'($unsigned($random(seed)) % 36);
  endfunction

  // strobes low for two cycles, then one idle cycle
  task automatic io_write(input io_addr_t a, input io_data_t d);
    @(posedge clk);
    #2;
    addr    = a;
    wr_data = d;
    iorq_n  = 1'b0;
    wr_n    = 1'b0;
    @(posedge clk);
    #2;
    @(posedge clk);
    #2;
    iorq_n = 1'b1;
    wr_n   = 1'b1;
  endtask

  // data is taken in the first cycle, before any pop can move the rx head
  task automatic io_read(input io_addr_t a, output io_data_t d, output logic oe);
    @(posedge clk);
    #2;
    addr   = a;
    iorq_n = 1'b0;
    rd_n   = 1'b0;
    @(negedge clk);
    d  = rd_data;
    oe = doe;
    @(posedge clk);
    #2;
    @(posedge clk);
    #2;
    iorq_n = 1'b1;
    rd_n   = 1'b1;
  endtask

  task automatic read_expect(input logic [2:0] offset, input io_data_t exp, input string what);
    io_data_t d;
    logic     oe;
    io_read(reg_addr(offset), d, oe);
    check_data(d, exp, what);
    check_bit(oe, 1'b1, {what, " doe"});
  endtask

  task automatic wait_status(input int bit_pos);
    io_data_t d;
    logic     oe;
    int       tries;
    tries = 0;
    d     = '0;
    while (!d[bit_pos] && tries < 30)
    begin
      io_read(reg_addr(reg_status), d, oe);
      tries = tries + 1;
    end
    if (!d[bit_pos])
      stop_on_error($sformatf("status bit %0d was still clear after %0d reads",
                              bit_pos, tries));
  endtask

  task automatic send_rx_frame(input int len);
    byte_t b;
    rx_sent.delete();
    for (int i = 0; i < len; i++)
    begin
      b = byte_t'($random(seed));
      rx_sent.push_back(b);
      @(posedge clk);
      #2;
      gmii_rx_dv = 1'b1;
      gmii_rxd   = b;
    end
    @(posedge clk);
    #2;
    gmii_rx_dv = 1'b0;
    gmii_rxd   = '0;
  endtask

  task automatic read_rx_len(output frame_len_t len);
    io_data_t lo;
    io_data_t hi;
    logic     oe;
    io_read(reg_addr(reg_rx_len0), lo, oe);
    io_read(reg_addr(reg_rx_len1), hi, oe);
    len = {hi, lo};
  endtask

  task automatic reset_defaults();
    io_data_t d;
    logic     oe;
    check_bit(int_n, 1'b1, "int_n after reset");
    check_bit(gmii_tx_en, 1'b0, "gmii_tx_en after reset");
    check_bit(status_msk[stat_rx_done], 1'b0, "status_msk rx bit after reset");
    check_bit(status_msk[stat_tx_done], 1'b0, "status_msk tx bit after reset");
    for (int i = 0; i < 8; i++)
      read_expect(3'(i), 8'd0, $sformatf("register %0d after reset", i));
    io_read(16'h0020, d, oe);
    check_data(d, expected_vector, "read outside the block");
    check_bit(oe, 1'b0, "doe outside the block");
  endtask

  task automatic register_readback();
    io_write(reg_addr(reg_status_msk), 8'h03);
    read_expect(reg_status_msk, 8'h03, "status mask");
    check_bit(status_msk[stat_rx_done], 1'b1, "status_msk rx bit set");
    check_bit(status_msk[stat_tx_done], 1'b1, "status_msk tx bit set");
    io_write(reg_addr(reg_cfg), 8'h01);
    read_expect(reg_cfg, 8'h01, "cfg set");
    io_write(reg_addr(reg_cfg), 8'h00);
    read_expect(reg_cfg, 8'h00, "cfg cleared");
    io_write(reg_addr(reg_status_msk), 8'h00);
    read_expect(reg_status_msk, 8'h00, "status mask cleared");
    check_bit(status_msk[stat_rx_done], 1'b0, "status_msk rx bit cleared");
    check_bit(status_msk[stat_tx_done], 1'b0, "status_msk tx bit cleared");
    io_write(reg_addr(reg_status), 8'h03);
    read_expect(reg_status, 8'h00, "status after writing ones");
  endtask

  task automatic receive_armed_frame();
    int         len;
    frame_len_t got_len;
    len = random_len();
    io_write(reg_addr(reg_control), 8'h01);
    read_expect(reg_control, 8'h01, "control armed");
    send_rx_frame(len);
    wait_status(stat_rx_done);
    read_expect(reg_control, 8'h00, "control after the frame");
    read_rx_len(got_len);
    check_len(got_len, frame_len_t'(len), "received frame length");
    last_rx_len = frame_len_t'(len);
    for (int i = 0; i < len; i++)
      read_expect(reg_rx_data, rx_sent[i], $sformatf("received byte %0d", i));
    io_write(reg_addr(reg_status), 8'h01);
    read_expect(reg_status, 8'h00, "status after clearing rx done");
  endtask

  task automatic ignore_unarmed_frame();
    frame_len_t got_len;
    send_rx_frame(random_len());
    // a captured frame would set the status two clocks after rx_dv falls
    repeat (3) @(posedge clk);
    read_expect(reg_status, 8'h00, "status after an unarmed frame");
    read_rx_len(got_len);
    check_len(got_len, last_rx_len, "length after an unarmed frame");
    read_expect(reg_rx_data, 8'h00, "rx data after an unarmed frame");
  endtask

  task automatic transmit_frame();
    int    len;
    byte_t sent[$];
    byte_t b;
    len = random_len();
    tx_seen.delete();
    tx_pulses = 0;
    for (int i = 0; i < len; i++)
    begin
      b = byte_t'($random(seed));
      sent.push_back(b);
      io_write(reg_addr(reg_tx_data), b);
    end
    check_len(frame_len_t'(tx_seen.size()), 16'd0, "bytes sent before cfg");
    io_write(reg_addr(reg_cfg), 8'h01);
    wait_status(stat_tx_done);
    check_bit(gmii_tx_en, 1'b0, "gmii_tx_en after the frame");
    check_len(frame_len_t'(tx_seen.size()), frame_len_t'(len), "transmitted byte count");
    check_bit(tx_pulses == 1, 1'b1, "single gmii_tx_en pulse");
    for (int i = 0; i < len; i++)
      check_data(tx_seen[i], sent[i], $sformatf("transmitted byte %0d", i));
    io_write(reg_addr(reg_cfg), 8'h00);
    io_write(reg_addr(reg_status), 8'h02);
    read_expect(reg_status, 8'h00, "status after clearing tx done");
  endtask

  task automatic interrupt_masking();
    check_bit(int_n, 1'b1, "int_n before the frame");
    io_write(reg_addr(reg_control), 8'h01);
    send_rx_frame(random_len());
    wait_status(stat_rx_done);
    check_bit(int_n, 1'b0, "int_n with rx done unmasked");
    io_write(reg_addr(reg_status_msk), 8'h01);
    check_bit(int_n, 1'b1, "int_n with rx done masked");
    io_write(reg_addr(reg_status_msk), 8'h00);
    check_bit(int_n, 1'b0, "int_n after unmasking");
    io_write(reg_addr(reg_status), 8'h01);
    check_bit(int_n, 1'b1, "int_n after clearing rx done");
  endtask

  initial
  begin
    seed        = 57143;
    errors      = 0;
    tx_pulses   = 0;
    tx_en_prev  = 1'b0;
    last_rx_len = '0;
    reset       = 1'b1;
    addr        = '0;
    wr_data     = '0;
    rd_n        = 1'b1;
    wr_n        = 1'b1;
    iorq_n      = 1'b1;
    gmii_rx_dv  = 1'b0;
    gmii_rxd    = '0;
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;

    reset_defaults();
    register_readback();
    receive_armed_frame();
    ignore_unarmed_frame();
    transmit_frame();
    interrupt_masking();

    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- project.f
gmii_bus_pkg.sv
gmii_frame_pkg.sv
gmii_byte_fifo.sv
simple_gmii_regs.sv
gmii_rx_frame.sv
gmii_tx_frame.sv
simple_gmii.sv
tb_simple_gmii.sv

//--- Makefile
# Verilator flow for the GMII byte port
# any variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_simple_gmii
RTL_TOP   ?= simple_gmii
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
